//--- verilog.f
design/gf_pkg.sv
design/rs_pkg.sv
design/rs_symbol_counter.sv
design/rs_syndrome_cell.sv
design/rs_decode_syndrome.sv
test/rs_syndrome_assertions.sv
test/rs_syndrome_tb.sv

//--- test/rs_syndrome_tb.sv
/* testbench for the RS syndrome stage with stimulus, reference syndromes,
   compare process and timeout */

`timescale 1ns/1ns

module rs_syndrome_tb
   import gf_pkg::*, rs_pkg::*;
();

   localparam int NUM_SYNDROMES  = DEFAULT_NUM_SYNDROMES;
   localparam int NUM_BLOCKS     = 6;            // codewords checked in the run
   localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 2 * CODE_LENGTH + 100;

   typedef symbol_t block_t [CODE_LENGTH];
   typedef symbol_t [NUM_SYNDROMES-1:0] syndrome_set_t;

   logic                CLK;
   logic                RESET;
   logic                enable;
   logic                sync;
   symbol_t             data_in;
   syndrome_set_t       syndromes;
   logic                done;

   block_t              cur_block;               // codeword being sent
   syndrome_set_t       expected_q[$];           // one entry per finished block
   syndrome_set_t       expected_set;
   int                  blocks_checked;
   int                  cycle_count;
   logic                prev_done;
   logic                prev_enable;

   rs_decode_syndrome #(
      .NUM_SYNDROMES (NUM_SYNDROMES)
   ) rs_decode_syndrome_inst (
      .CLK       (CLK),
      .RESET     (RESET),
      .enable    (enable),
      .sync      (sync),
      .data_in   (data_in),
      .syndromes (syndromes),
      .done      (done)
   );

   always #4 CLK = ~CLK;                         // 8 ns period

   //------------------------------------------------------------
   // reference model and checks
   //------------------------------------------------------------
   // Horner evaluation of the received polynomial at alpha^idx
   function automatic symbol_t ref_syndrome(input block_t blk, input int idx);
      symbol_t acc;
      acc = '0;
      for (int j = 0; j < CODE_LENGTH; j++) begin
         for (int k = 0; k < idx; k++) begin
            acc = gf_mul_alpha(acc);
         end
         acc = acc ^ blk[j];
      end
      return acc;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_syndrome(input int idx, input symbol_t actual, input symbol_t expected);
      if (actual !== expected) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: syndrome S_%0d is %h, expected %h",
                             $time, idx, actual, expected));
      end
   endtask

   task automatic check_done(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: done is %b, expected %b (%s)",
                             $time, actual, expected, what));
      end
   endtask

   //------------------------------------------------------------
   // stimulus helpers
   //------------------------------------------------------------
   task automatic drive_symbol(input logic first, input symbol_t value);
      @(posedge CLK);
      #1;
      enable  = 1'b1;
      sync    = first;
      data_in = value;
   endtask

   // noise on sync and data must be ignored while enable is low
   task automatic idle_cycle(input bit noise);
      @(posedge CLK);
      #1;
      enable  = 1'b0;
      sync    = noise ? logic'($urandom % 2) : 1'b0;
      data_in = noise ? symbol_t'($urandom) : '0;
   endtask

   task automatic send_block(input bit zero_data, input bit with_gaps);
      syndrome_set_t expected;
      int            gap;
      for (int j = 0; j < CODE_LENGTH; j++) begin
         cur_block[j] = zero_data ? symbol_t'(0) : symbol_t'($urandom);
      end
      for (int j = 0; j < CODE_LENGTH; j++) begin
         if (with_gaps && (j > 0) && (($urandom % 4) == 0)) begin
            gap = 1 + ($urandom % 3);
            for (int g = 0; g < gap; g++) begin
               idle_cycle(1'b1);
               @(negedge CLK);
               check_done(done, 1'b0, "gap inside a block");
            end
         end
         drive_symbol(j == 0, cur_block[j]);
      end
      for (int i = 0; i < NUM_SYNDROMES; i++) begin
         expected[i] = ref_syndrome(cur_block, i);
      end
      expected_q.push_back(expected);
   endtask

   task automatic wait_checked(input int count);
      while (blocks_checked < count) begin
         @(posedge CLK);
      end
   endtask

   //------------------------------------------------------------
   // compare process
   //------------------------------------------------------------
   // enable is driven after the rising edge, so at the falling edge it
   // shows what the next edge samples
   always @(negedge CLK) begin
      if (RESET) begin
         if (done && !prev_done) begin
            if (expected_q.size() == 0) begin
               abort_run("done rose although no codeword was outstanding");
            end
            else begin
               expected_set = expected_q.pop_front();
               for (int i = 0; i < NUM_SYNDROMES; i++) begin
                  check_syndrome(i, syndromes[i], expected_set[i]);
               end
               blocks_checked = blocks_checked + 1;
            end
         end
         else if (prev_done && prev_enable) begin
            check_done(done, 1'b0, "first enabled cycle after done");
         end
         else if (prev_done) begin
            check_done(done, 1'b1, "done held while enable low");
         end
         prev_done   = done;
         prev_enable = enable;
      end
   end

   always @(posedge CLK) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("timeout: done never came within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   //------------------------------------------------------------
   // test sequence
   //------------------------------------------------------------
   initial begin
      void'($urandom(32'he7f2));                 // seeds the generator once
      CLK            = 1'b0;
      RESET          = 1'b0;
      enable         = 1'b0;
      sync           = 1'b0;
      data_in        = '0;
      blocks_checked = 0;
      cycle_count    = 0;
      prev_done      = 1'b0;
      prev_enable    = 1'b0;
      repeat (4) @(posedge CLK);
      #1;
      RESET = 1'b1;
      @(negedge CLK);
      check_done(done, 1'b0, "after reset");
      for (int i = 0; i < NUM_SYNDROMES; i++) begin
         check_syndrome(i, syndromes[i], '0);
      end

      send_block(1'b1, 1'b0);                    // all-zero codeword
      idle_cycle(1'b0);
      wait_checked(1);
      repeat (3) idle_cycle(1'b0);
      send_block(1'b0, 1'b0);                    // random, no gaps
      idle_cycle(1'b1);
      wait_checked(2);
      repeat (2) idle_cycle(1'b1);
      send_block(1'b0, 1'b1);                    // random with gaps
      idle_cycle(1'b0);
      wait_checked(3);

      // abandoned partial block, restarted by a new sync
      for (int j = 0; j < 100; j++) begin
         drive_symbol(j == 0, symbol_t'($urandom));
      end
      send_block(1'b0, 1'b0);
      idle_cycle(1'b0);
      wait_checked(4);

      send_block(1'b0, 1'b0);                    // back to back pair
      send_block(1'b0, 1'b0);
      idle_cycle(1'b0);
      wait_checked(NUM_BLOCKS);
      repeat (4) idle_cycle(1'b0);

      if ((blocks_checked == NUM_BLOCKS) && (expected_q.size() == 0)) begin
         $display("NO ERRORS");
         $finish;
      end
      else begin
         abort_run($sformatf("only %0d of %0d blocks were checked",
                             blocks_checked, NUM_BLOCKS));
      end
   end

endmodule

//--- test/rs_syndrome_assertions.sv
/* concurrent checks on the symbol counter for sync load, hold while
   disabled and done rise, bound into rs_symbol_counter */

`timescale 1ns/1ns

module rs_syndrome_counter_assertions
   import rs_pkg::*;
(
   input logic   CLK,                            // system clock
   input logic   RESET,                          // async reset, active low
   input logic   enable,                         // symbol qualifier
   input logic   sync,                           // first symbol of a block
   input count_t count,                          // position counter
   input logic   done                            // block complete
);

   //------------------------------------------------------------
   // counter behavior
   //------------------------------------------------------------
   // an enabled sync always restarts at position 1
   sync_loads_one: assert property (
      @(posedge CLK) disable iff (!RESET)
      (enable && sync) |=> (count == count_t'(1))
   ) else $error("counter did not restart at 1 after an enabled sync");

   // nothing moves while the source has no symbol
   hold_when_disabled: assert property (
      @(posedge CLK) disable iff (!RESET)
      !enable |=> ($stable(count) && $stable(done))
   ) else $error("counter or done changed on a cycle with enable low");

   //------------------------------------------------------------
   // done decode
   //------------------------------------------------------------
   // done only comes from an enabled step onto the last position
   done_only_at_end: assert property (
      @(posedge CLK) disable iff (!RESET)
      $rose(done) |-> $past(enable && !sync && (count == count_t'(CODE_LENGTH - 1)))
   ) else $error("done rose without an enabled step onto the last position");

endmodule

bind rs_symbol_counter rs_syndrome_counter_assertions rs_syndrome_counter_assertions_inst (
   .CLK    (CLK),
   .RESET  (RESET),
   .enable (enable),
   .sync   (sync),
   .count  (count),
   .done   (done)
);

//--- design/rs_decode_syndrome.sv
/* RS decoder syndrome stage: block counter plus one accumulator
   cell per syndrome */

`timescale 1ns/1ns

module rs_decode_syndrome
   import gf_pkg::*, rs_pkg::*;
#(
   parameter int unsigned NUM_SYNDROMES = DEFAULT_NUM_SYNDROMES // 2t
)
(
   input  logic                        CLK,      // system clock
   input  logic                        RESET,    // async reset, active low
   input  logic                        enable,   // symbol qualifier
   input  logic                        sync,     // first symbol of a block
   input  symbol_t                     data_in,  // received symbol
   output symbol_t [NUM_SYNDROMES-1:0] syndromes, // S_0 in the low symbol
   output logic                        done      // syndromes valid
);

   //------------------------------------------------------------
   // block position and done
   //------------------------------------------------------------
   rs_symbol_counter rs_symbol_counter_inst (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .sync   (sync),
      .done   (done)
   );

   //------------------------------------------------------------
   // syndrome accumulators
   //------------------------------------------------------------
   // cell i evaluates the received polynomial at alpha^i
   for (genvar i = 0; i < NUM_SYNDROMES; i++) begin : g_cell
      rs_syndrome_cell #(
         .POWER (i)
      ) rs_syndrome_cell_inst (
         .CLK      (CLK),
         .RESET    (RESET),
         .enable   (enable),
         .sync     (sync),
         .data_in  (data_in),
         .syndrome (syndromes[i])
      );
   end

endmodule

//--- design/rs_syndrome_cell.sv
/* one syndrome accumulator: Horner step with a constant
   multiplier by alpha^POWER */

`timescale 1ns/1ns

module rs_syndrome_cell
   import gf_pkg::*;
#(
   parameter int unsigned POWER = 1              // syndrome index
)
(
   input  logic    CLK,                          // system clock
   input  logic    RESET,                        // async reset, active low
   input  logic    enable,                       // symbol qualifier
   input  logic    sync,                         // first symbol of a block
   input  symbol_t data_in,                      // received symbol
   output symbol_t syndrome                      // running syndrome value
);

   //------------------------------------------------------------
   // constant multiplier
   //------------------------------------------------------------
   symbol_t product;                             // syndrome times alpha^POWER

   // POWER 0 leaves the register untouched here
   always_comb begin
      product = gf_mul_alpha_pow(syndrome, POWER);
   end

   //------------------------------------------------------------
   // accumulator
   //------------------------------------------------------------
   // S <- S * alpha^POWER + r, with the sync symbol as the seed
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         syndrome <= '0;
      end
      else if (enable) begin
         if (sync) begin
            syndrome <= data_in;                 // restart the polynomial
         end
         else begin
            syndrome <= product ^ data_in;       // GF add is XOR
         end
      end
   end

endmodule

//--- design/rs_symbol_counter.sv
/* symbol position counter with start-of-block sync and done flag */

`timescale 1ns/1ns

module rs_symbol_counter
   import rs_pkg::*;
(
   input  logic CLK,                             // system clock
   input  logic RESET,                           // async reset, active low
   input  logic enable,                          // symbol qualifier
   input  logic sync,                            // first symbol of a block
   output logic done                             // block complete
);

   //------------------------------------------------------------
   // position counter
   //------------------------------------------------------------
   count_t count;                                // symbols seen in this block

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         count <= '0;
      end
      else if (enable) begin
         if (sync) begin
            count <= count_t'(1);                // sync symbol is position 1
         end
         else if ((count == '0) || (count == count_t'(CODE_LENGTH))) begin
            count <= '0;                         // idle until next sync
         end
         else begin
            count <= count + count_t'(1);
         end
      end
   end

   //------------------------------------------------------------
   // done decode
   //------------------------------------------------------------
   // high from the edge after the last symbol until the next
   // enabled cycle moves the counter on
   assign done = (count == count_t'(CODE_LENGTH));

endmodule

//--- design/rs_pkg.sv
/* RS(255) code frame constants, position counter type and
   default syndrome count */

package rs_pkg;

   //------------------------------------------------------------
   // code frame
   //------------------------------------------------------------
   localparam int CODE_LENGTH = 255;             // symbols per codeword

   // position 0 means idle, CODE_LENGTH means block complete
   typedef logic [$clog2(CODE_LENGTH+1)-1:0] count_t;

   //------------------------------------------------------------
   // decoder defaults
   //------------------------------------------------------------
   // 22 syndromes corrects up to 11 symbol errors
   localparam int DEFAULT_NUM_SYNDROMES = 22;

endpackage

//--- design/gf_pkg.sv
/* GF(2^8) symbol type, field polynomial and constant multiply functions
   used to build the syndrome multipliers at elaboration */

package gf_pkg;

   //------------------------------------------------------------
   // field parameters
   //------------------------------------------------------------
   localparam int GF_WIDTH = 8;                  // bits per symbol

   // generator polynomial x^8+x^4+x^3+x^2+1
   localparam logic [GF_WIDTH:0] GF_POLY = 9'h11D;

   typedef logic [GF_WIDTH-1:0] symbol_t;        // field element / received symbol

   //------------------------------------------------------------
   // multiply by alpha
   //------------------------------------------------------------
   // alpha is the root of GF_POLY, so multiplying by it is a left
   // shift, folded back by the low bits of the polynomial when the
   // top bit falls out
   function automatic symbol_t gf_mul_alpha(input symbol_t value);
      symbol_t shifted;
      shifted = {value[GF_WIDTH-2:0], 1'b0};     // times x
      if (value[GF_WIDTH-1]) begin
         shifted = shifted ^ GF_POLY[GF_WIDTH-1:0]; // reduce x^8
      end
      return shifted;
   endfunction

   //------------------------------------------------------------
   // multiply by alpha^power
   //------------------------------------------------------------
   // repeated alpha steps; with a constant power and a signal operand
   // this collapses to a fixed XOR matrix, one row per output bit
   function automatic symbol_t gf_mul_alpha_pow(input symbol_t value,
                                                input int unsigned power);
      symbol_t     result;
      int unsigned order;
      int unsigned steps;
      order  = (1 << GF_WIDTH) - 1;              // multiplicative group size
      steps  = power % order;                    // alpha^255 is 1
      result = value;
      // fixed trip count keeps the loop static for synthesis
      for (int unsigned i = 0; i < order; i++) begin
         if (i < steps) begin
            result = gf_mul_alpha(result);
         end
      end
      return result;
   endfunction

endpackage
